// File: board_cfg_pkg.sv
package board_cfg_pkg;

    ////////////////////
    // trigger opcodes
    ////////////////////

    // opcode sent with each trigger strobe
    // value 3 is spare and loads nothing
    typedef enum logic [1:0]
    {
        TRIG_NONE     = 2'd0,
        TRIG_HALF_CNT = 2'd1,
        TRIG_BLK_SIZE = 2'd2
    } trig_op_e;

    // data word that travels with the strobe
    localparam int unsigned TRIG_DATA_W = 16;

    ////////////////////
    // configuration
    ////////////////////

    // divider register width
    localparam int unsigned HALF_CNT_W = 16;

    // tick period is half_cnt + 1 clocks, so 4 clocks out of reset
    localparam logic [HALF_CNT_W-1:0] HALF_CNT_DEFAULT = 16'd3;

    // ring block size out of reset
    // gives a lag of 15 ticks
    localparam int unsigned BLK_SIZE_DEFAULT = 20;

endpackage

// File: config_regs.sv
`timescale 1ns/1ps

module config_regs
(
    input  logic                                    ep50trig,
    input  logic                                    reset_sim,
    input  logic                                    i_trig_valid,
    input  board_cfg_pkg::trig_op_e                 i_trig_op,
    input  logic [board_cfg_pkg::TRIG_DATA_W-1:0]   i_trig_data,
    output logic [board_cfg_pkg::HALF_CNT_W-1:0]    o_half_cnt,
    output spike_path_pkg::ring_addr_t              o_blk_size
);

    ////////////////////
    // trigger decode
    ////////////////////

    // one strobe loads one register
    // new value shows on the next clock
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_half_cnt <= board_cfg_pkg::HALF_CNT_DEFAULT;
            o_blk_size <= spike_path_pkg::ring_addr_t'(board_cfg_pkg::BLK_SIZE_DEFAULT);
        end
        else if (i_trig_valid)
        begin
            case (i_trig_op)
                // tick divider, full data word
                board_cfg_pkg::TRIG_HALF_CNT:
                begin
                    o_half_cnt <= i_trig_data;
                end
                // block size, low byte only
                board_cfg_pkg::TRIG_BLK_SIZE:
                begin
                    o_blk_size <= i_trig_data[spike_path_pkg::RING_ADDR_W-1:0];
                end
                // TRIG_NONE and the spare code
                default:
                begin
                    o_half_cnt <= o_half_cnt;
                    o_blk_size <= o_blk_size;
                end
            endcase
        end
    end

endmodule

// File: list.f
board_cfg_pkg.sv
spike_path_pkg.sv
ring_addr_if.sv
config_regs.sv
tick_gen.sv
ring_addr_gen.sv
spike_ram_stage.sv
spike_counter.sv
spike_delay_top.sv
tb_spike_delay.sv

// File: ring_addr_gen.sv
`timescale 1ns/1ps

module ring_addr_gen
(
    input  logic                        ep50trig,
    input  logic                        reset_sim,
    input  logic                        i_tick,
    input  spike_path_pkg::ring_addr_t  i_blk_size,
    ring_addr_if.gen                    ring
);

    spike_path_pkg::ring_state_e    state;
    spike_path_pkg::ring_addr_t     wr_addr;
    spike_path_pkg::ring_addr_t     rd_addr;
    spike_path_pkg::ring_addr_t     blk_size_copy;
    spike_path_pkg::ring_addr_t     wr_addr_next;
    spike_path_pkg::ring_addr_t     rd_addr_next;
    spike_path_pkg::ring_addr_t     fill_mark;
    logic                           blk_changed;

    // restart when the block size moves
    assign blk_changed = (i_blk_size != blk_size_copy);

    // both indices wrap after blk_size
    assign wr_addr_next = (wr_addr == blk_size_copy) ? '0 : wr_addr + 1'b1;
    assign rd_addr_next = (rd_addr == blk_size_copy) ? '0 : rd_addr + 1'b1;

    // lag of the ring in ticks
    assign fill_mark = blk_size_copy - spike_path_pkg::READ_WRITE_DIFF;

    ////////////////////
    // ring fsm
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            state         <= spike_path_pkg::RING_FILL;
            wr_addr       <= '0;
            rd_addr       <= '0;
            blk_size_copy <= spike_path_pkg::ring_addr_t'(board_cfg_pkg::BLK_SIZE_DEFAULT);
        end
        else if (i_tick)
        begin
            if (blk_changed)
            begin
                // drop the old contents, refill with the new size
                state         <= spike_path_pkg::RING_FILL;
                wr_addr       <= '0;
                rd_addr       <= '0;
                blk_size_copy <= i_blk_size;
            end
            else
            begin
                wr_addr <= wr_addr_next;
                case (state)
                    spike_path_pkg::RING_FILL:
                    begin
                        // lead reached, read side steps off slot 0 here
                        if (wr_addr_next == fill_mark)
                        begin
                            state   <= spike_path_pkg::RING_RUN;
                            rd_addr <= rd_addr_next;
                        end
                    end
                    default:
                    begin
                        rd_addr <= rd_addr_next;
                    end
                endcase
            end
        end
    end

    // no write on the restart tick
    assign ring.wr_en    = i_tick && !blk_changed;
    assign ring.wr_addr  = wr_addr;
    assign ring.rd_addr  = rd_addr;
    assign ring.rd_valid = (state == spike_path_pkg::RING_RUN);

endmodule

// File: ring_addr_if.sv
`timescale 1ns/1ps

interface ring_addr_if;

    // write strobe, already qualified by the tick
    logic                       wr_en;
    spike_path_pkg::ring_addr_t wr_addr;
    spike_path_pkg::ring_addr_t rd_addr;
    // high once the ring has filled
    logic                       rd_valid;

    // address generator side
    modport gen (output wr_en, output wr_addr, output rd_addr, output rd_valid);

    // memory stage side, both stages share one generator
    modport stage (input wr_en, input wr_addr, input rd_addr, input rd_valid);

endinterface

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" && rm -rf obj_dir sim.log build.log && \
    verilator --binary --timing -Wno-fatal --top-module tb_spike_delay \
        -f list.f -o tb_spike_delay > build.log 2>&1 && \
    ./obj_dir/tb_spike_delay > sim.log 2>&1
grep -q "Verification passed" sim.log && echo "simulation ok" || { echo "simulation not ok, see build.log and sim.log"; exit 1; }

// File: spike_counter.sv
`timescale 1ns/1ps

module spike_counter
(
    input  logic                            ep50trig,
    input  logic                            reset_sim,
    input  logic                            i_tick,
    input  logic                            i_window_end,
    input  logic                            i_spike,
    output spike_path_pkg::spike_count_t    o_count,
    output logic                            o_count_valid
);

    // running total of the open window
    spike_path_pkg::spike_count_t   acc;
    spike_path_pkg::spike_count_t   acc_next;

    // spike bit sampled on this tick
    assign acc_next = acc + spike_path_pkg::spike_count_t'(i_spike);

    ////////////////////
    // window count
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            acc           <= '0;
            o_count       <= '0;
            o_count_valid <= 1'b0;
        end
        else
        begin
            // single cycle pulse
            o_count_valid <= 1'b0;
            if (i_tick)
            begin
                if (i_window_end)
                begin
                    // total includes the closing tick
                    o_count       <= acc_next;
                    o_count_valid <= 1'b1;
                    acc           <= '0;
                end
                else
                begin
                    acc <= acc_next;
                end
            end
        end
    end

endmodule

// File: spike_delay_top.sv
`timescale 1ns/1ps

module spike_delay_top
(
    input  logic                                    ep50trig,
    input  logic                                    reset_sim,
    input  logic                                    i_trig_valid,
    input  board_cfg_pkg::trig_op_e                 i_trig_op,
    input  logic [board_cfg_pkg::TRIG_DATA_W-1:0]   i_trig_data,
    input  logic                                    i_spike,
    output logic                                    o_tick,
    output logic                                    o_spike_delayed,
    output logic                                    o_spike_delayed_twice,
    output spike_path_pkg::spike_count_t            o_count_raw,
    output spike_path_pkg::spike_count_t            o_count_delayed,
    output spike_path_pkg::spike_count_t            o_count_delayed_twice,
    output logic                                    o_count_valid
);

    logic [board_cfg_pkg::HALF_CNT_W-1:0]   half_cnt;
    spike_path_pkg::ring_addr_t             blk_size;
    logic                                   window_end;

    // shared ring addresses
    ring_addr_if ring ();

    ////////////////////
    // config and ticks
    ////////////////////

    config_regs u_config_regs
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_trig_valid (i_trig_valid),
        .i_trig_op    (i_trig_op),
        .i_trig_data  (i_trig_data),
        .o_half_cnt   (half_cnt),
        .o_blk_size   (blk_size)
    );

    tick_gen u_tick_gen
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_half_cnt   (half_cnt),
        .o_tick       (o_tick),
        .o_window_end (window_end)
    );

    ////////////////////
    // delay line
    ////////////////////

    ring_addr_gen u_ring_addr_gen
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_tick     (o_tick),
        .i_blk_size (blk_size),
        .ring       (ring.gen)
    );

    // first lag
    spike_ram_stage u_stage_1
    (
        .ep50trig        (ep50trig),
        .reset_sim       (reset_sim),
        .i_tick          (o_tick),
        .i_spike         (i_spike),
        .ring            (ring.stage),
        .o_spike_delayed (o_spike_delayed)
    );

    // second lag fed from the first
    spike_ram_stage u_stage_2
    (
        .ep50trig        (ep50trig),
        .reset_sim       (reset_sim),
        .i_tick          (o_tick),
        .i_spike         (o_spike_delayed),
        .ring            (ring.stage),
        .o_spike_delayed (o_spike_delayed_twice)
    );

    ////////////////////
    // counters
    ////////////////////

    // raw counter also supplies the shared valid pulse
    spike_counter u_count_raw
    (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_tick        (o_tick),
        .i_window_end  (window_end),
        .i_spike       (i_spike),
        .o_count       (o_count_raw),
        .o_count_valid (o_count_valid)
    );

    // same window timing as the raw counter
    spike_counter u_count_delayed
    (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_tick        (o_tick),
        .i_window_end  (window_end),
        .i_spike       (o_spike_delayed),
        .o_count       (o_count_delayed),
        .o_count_valid ()
    );

    spike_counter u_count_delayed_twice
    (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_tick        (o_tick),
        .i_window_end  (window_end),
        .i_spike       (o_spike_delayed_twice),
        .o_count       (o_count_delayed_twice),
        .o_count_valid ()
    );

endmodule

// File: spike_path_pkg.sv
package spike_path_pkg;

    ////////////////////
    // ring buffer
    ////////////////////

    localparam int unsigned RING_ADDR_W = 8;
    localparam int unsigned RING_DEPTH  = 2 ** RING_ADDR_W;

    typedef logic [RING_ADDR_W-1:0] ring_addr_t;

    // write side lead before the read side starts
    localparam ring_addr_t READ_WRITE_DIFF = 8'd5;

    // fill until the lead is built, then stream
    typedef enum logic
    {
        RING_FILL = 1'b0,
        RING_RUN  = 1'b1
    } ring_state_e;

    ////////////////////
    // counting window
    ////////////////////

    localparam int unsigned COUNT_W = 16;

    typedef logic [COUNT_W-1:0] spike_count_t;

    // neuron ticks per counting window
    localparam int unsigned TICKS_PER_WINDOW = 8;
    localparam int unsigned WIN_CNT_W        = $clog2(TICKS_PER_WINDOW);

    typedef logic [WIN_CNT_W-1:0] win_cnt_t;

    // index of the last tick in a window
    localparam win_cnt_t WIN_LAST = win_cnt_t'(TICKS_PER_WINDOW - 1);

endpackage

// File: spike_ram_stage.sv
`timescale 1ns/1ps

module spike_ram_stage
(
    input  logic        ep50trig,
    input  logic        reset_sim,
    input  logic        i_tick,
    input  logic        i_spike,
    ring_addr_if.stage  ring,
    output logic        o_spike_delayed
);

    // one bit per ring slot
    logic   spike_mem [0:spike_path_pkg::RING_DEPTH-1];
    logic   rd_bit;

    always_ff @(posedge ep50trig)
    begin
        if (ring.wr_en)
            spike_mem[ring.wr_addr] <= i_spike;
    end

    // same slot on both sides only at a lag of one tick
    // the incoming bit is the one wanted there
    assign rd_bit = (ring.wr_en && (ring.wr_addr == ring.rd_addr)) ? i_spike
                                                                   : spike_mem[ring.rd_addr];

    // output moves on ticks only
    // 0 while the ring is not streaming
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_spike_delayed <= 1'b0;
        end
        else if (i_tick)
        begin
            if (ring.rd_valid)
                o_spike_delayed <= rd_bit;
            else
                o_spike_delayed <= 1'b0;
        end
    end

endmodule

// File: spike_testdata.txt
# T <op hex> <data hex> : trigger, op 0 none, 1 tick divider, 2 block size
# S <hex byte> : spike bits for one window of 8 ticks, bit 0 first
# W <raw> <delayed> <twice> : decimal counts of the window just closed
S a5
W 4 0 0
S 3c
T 1 0001
W 4 0 0
S ff
W 8 3 0
S 81
T 1 0005
W 2 5 0
S 0f
W 4 8 3
S 00
T 2 000a
W 0 2 6
S 6e
T 0 ffff
W 5 3 2
S b3
T 2 000a
W 5 5 3
S 00
W 0 3 5

// File: tb_spike_delay.sv
`timescale 1ns/1ps

module tb_spike_delay;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int MAX_TICKS      = 256;
    localparam int WIN            = spike_path_pkg::TICKS_PER_WINDOW;

    logic                                   ep50trig;
    logic                                   reset_sim;
    logic                                   i_trig_valid;
    board_cfg_pkg::trig_op_e                i_trig_op;
    logic [board_cfg_pkg::TRIG_DATA_W-1:0]  i_trig_data;
    logic                                   i_spike;
    logic                                   o_tick;
    logic                                   o_spike_delayed;
    logic                                   o_spike_delayed_twice;
    spike_path_pkg::spike_count_t           o_count_raw;
    spike_path_pkg::spike_count_t           o_count_delayed;
    spike_path_pkg::spike_count_t           o_count_delayed_twice;
    logic                                   o_count_valid;

    int     seed;
    int     value_errors;
    int     timeout_errors;
    int     protocol_errors;
    int     parse_errors;
    logic   aborted;

    // delay line model, one entry per tick
    logic   hist [0:MAX_TICKS-1];
    logic   exp1 [0:MAX_TICKS-1];
    logic   exp2 [0:MAX_TICKS-1];
    int     tick_idx;
    int     lag;
    int     ring_start;
    int     new_lag;
    int     new_start;
    int     switch_tick;
    logic   restart_pending;
    logic   switch_pending;
    spike_path_pkg::ring_addr_t blk_model;

    // tick period tracking
    int     cycle_cnt;
    int     last_tick_cycle;
    int     exp_period;
    logic   skip_period;

    // window results, model side and dut side
    logic   window_pending;
    logic   seen_valid;
    spike_path_pkg::spike_count_t   win_raw;
    spike_path_pkg::spike_count_t   win_del;
    spike_path_pkg::spike_count_t   win_twice;
    spike_path_pkg::spike_count_t   last_raw;
    spike_path_pkg::spike_count_t   last_del;
    spike_path_pkg::spike_count_t   last_twice;

    spike_delay_top i_dut
    (
        .ep50trig              (ep50trig),
        .reset_sim             (reset_sim),
        .i_trig_valid          (i_trig_valid),
        .i_trig_op             (i_trig_op),
        .i_trig_data           (i_trig_data),
        .i_spike               (i_spike),
        .o_tick                (o_tick),
        .o_spike_delayed       (o_spike_delayed),
        .o_spike_delayed_twice (o_spike_delayed_twice),
        .o_count_raw           (o_count_raw),
        .o_count_delayed       (o_count_delayed),
        .o_count_delayed_twice (o_count_delayed_twice),
        .o_count_valid         (o_count_valid)
    );

    // 100 ns clock
    initial
    begin
        ep50trig = 1'b0;
        forever
            #50 ep50trig = ~ep50trig;
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_count(input string name, input spike_path_pkg::spike_count_t exp_val,
                               input spike_path_pkg::spike_count_t got_val);
        if (got_val !== exp_val)
        begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: %s expected %0d actual %0d", $time, name, exp_val, got_val);
        end
    endtask

    task automatic check_spike(input string name, input logic exp_val, input logic got_val);
        if (got_val !== exp_val)
        begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: %s expected %b actual %b", $time, name, exp_val, got_val);
        end
    endtask

    task automatic check_period(input int exp_val, input int got_val);
        if (got_val != exp_val)
        begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: o_tick period expected %0d actual %0d", $time, exp_val, got_val);
        end
    endtask

    // field count of one data record
    task automatic check_op(input byte kind, input int line_no, input int got, input int want);
        if (got != want)
        begin
            parse_errors = parse_errors + 1;
            $display("Record %c on line %0d does not parse, %0d of %0d fields read",
                     kind, line_no, got, want);
        end
    endtask

    ////////////////////
    // cycle stepping
    ////////////////////

    // one clock, inputs move 10 ns after the edge
    task automatic next_cycle();
        int filler;
        @(posedge ep50trig);
        #10;
        cycle_cnt = cycle_cnt + 1;
        i_trig_valid = 1'b0;
        // noise off the tick, the dut must ignore it
        filler = $random(seed);
        i_spike = filler[0];
        if (window_pending)
        begin
            window_pending = 1'b0;
            if (o_count_valid)
            begin
                seen_valid = 1'b1;
                last_raw   = o_count_raw;
                last_del   = o_count_delayed;
                last_twice = o_count_delayed_twice;
                check_count("o_count_raw", win_raw, o_count_raw);
                check_count("o_count_delayed", win_del, o_count_delayed);
                check_count("o_count_delayed_twice", win_twice, o_count_delayed_twice);
            end
            else
            begin
                protocol_errors = protocol_errors + 1;
                $display("At %0t o_count_valid did not pulse after the window end", $time);
            end
        end
        else if (o_count_valid)
        begin
            protocol_errors = protocol_errors + 1;
            $display("At %0t o_count_valid pulsed with no window end before it", $time);
        end
        // nothing published yet
        if (!seen_valid)
        begin
            check_count("o_count_raw", '0, o_count_raw);
            check_count("o_count_delayed", '0, o_count_delayed);
            check_count("o_count_delayed_twice", '0, o_count_delayed_twice);
        end
    endtask

    // wait for the next tick cycle and present one spike bit there
    task automatic run_tick(input logic spike_bit);
        int waited;
        int t;
        int k;
        waited = 0;
        next_cycle();
        while (!o_tick && waited < TIMEOUT_CYCLES)
        begin
            next_cycle();
            waited = waited + 1;
        end
        if (!o_tick)
        begin
            timeout_errors = timeout_errors + 1;
            aborted = 1'b1;
            $display("Timeout at %0t: o_tick did not rise within %0d cycles",
                     $time, TIMEOUT_CYCLES);
        end
        else if (tick_idx >= MAX_TICKS)
        begin
            protocol_errors = protocol_errors + 1;
            aborted = 1'b1;
            $display("Stimulus runs past the model history of %0d ticks", MAX_TICKS);
        end
        else
        begin
            t = tick_idx;
            i_spike = spike_bit;
            hist[t] = spike_bit;
            if (!skip_period)
                check_period(exp_period, cycle_cnt - last_tick_cycle);
            skip_period = 1'b0;
            last_tick_cycle = cycle_cnt;
            // first tick after a new block size clears the ring
            if (restart_pending)
            begin
                restart_pending = 1'b0;
                switch_pending  = 1'b1;
                new_start       = t + 1;
                switch_tick     = t + 2;
            end
            // output register still shows the old ring for one tick
            if (switch_pending && t == switch_tick)
            begin
                switch_pending = 1'b0;
                lag            = new_lag;
                ring_start     = new_start;
            end
            // the slot written on the start tick is skipped by the reader
            exp1[t] = (t - lag >= ring_start + 1) ? hist[t - lag] : 1'b0;
            exp2[t] = (t - 2 * lag >= ring_start + 1) ? hist[t - 2 * lag] : 1'b0;
            check_spike("o_spike_delayed", exp1[t], o_spike_delayed);
            check_spike("o_spike_delayed_twice", exp2[t], o_spike_delayed_twice);
            // window totals over the last 8 ticks
            if (t % WIN == WIN - 1)
            begin
                win_raw   = '0;
                win_del   = '0;
                win_twice = '0;
                for (k = t - WIN + 1; k <= t; k++)
                begin
                    win_raw   = win_raw + spike_path_pkg::spike_count_t'(hist[k]);
                    win_del   = win_del + spike_path_pkg::spike_count_t'(exp1[k]);
                    win_twice = win_twice + spike_path_pkg::spike_count_t'(exp2[k]);
                end
                window_pending = 1'b1;
            end
            tick_idx = t + 1;
        end
    endtask

    // one-cycle strobe, always in the cycle right after a tick
    task automatic apply_trigger(input board_cfg_pkg::trig_op_e op,
                                 input logic [board_cfg_pkg::TRIG_DATA_W-1:0] data);
        next_cycle();
        if (o_tick)
        begin
            protocol_errors = protocol_errors + 1;
            $display("At %0t a trigger fell on a tick cycle, stimulus out of step", $time);
        end
        i_trig_valid = 1'b1;
        i_trig_op    = op;
        i_trig_data  = data;
        case (op)
            board_cfg_pkg::TRIG_HALF_CNT:
            begin
                exp_period  = int'(data) + 1;
                skip_period = 1'b1;
            end
            board_cfg_pkg::TRIG_BLK_SIZE:
            begin
                if (data[spike_path_pkg::RING_ADDR_W-1:0] != blk_model)
                begin
                    blk_model       = data[spike_path_pkg::RING_ADDR_W-1:0];
                    new_lag         = int'(blk_model) - int'(spike_path_pkg::READ_WRITE_DIFF);
                    restart_pending = 1'b1;
                end
            end
            default:
            begin
                restart_pending = restart_pending;
            end
        endcase
    endtask

    ////////////////////
    // data records
    ////////////////////

    task automatic run_record(input string line, input int line_no);
        byte            kind;
        string          rest;
        int             fields;
        int             k;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    c;
        kind = line[0];
        rest = line.substr(1, line.len() - 1);
        a = '0;
        b = '0;
        c = '0;
        case (kind)
            "T":
            begin
                fields = $sscanf(rest, "%h %h", a, b);
                check_op(kind, line_no, fields, 2);
                if (fields == 2)
                    apply_trigger(board_cfg_pkg::trig_op_e'(a[1:0]), b[15:0]);
            end
            "S":
            begin
                // one window of bits, bit 0 first
                fields = $sscanf(rest, "%h", a);
                check_op(kind, line_no, fields, 1);
                if (fields == 1)
                begin
                    for (k = 0; k < WIN && !aborted; k++)
                        run_tick(a[k]);
                end
            end
            "W":
            begin
                fields = $sscanf(rest, "%d %d %d", a, b, c);
                check_op(kind, line_no, fields, 3);
                if (fields == 3)
                begin
                    // let the valid pulse of the closed window through
                    if (window_pending)
                        next_cycle();
                    check_count("o_count_raw", spike_path_pkg::spike_count_t'(a), last_raw);
                    check_count("o_count_delayed", spike_path_pkg::spike_count_t'(b), last_del);
                    check_count("o_count_delayed_twice", spike_path_pkg::spike_count_t'(c),
                                last_twice);
                end
            end
            default:
            begin
                parse_errors = parse_errors + 1;
                $display("Unknown record %c on line %0d", kind, line_no);
            end
        endcase
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        int     fd;
        int     rc;
        int     line_no;
        int     total;
        string  line;
        seed            = 32'h6ac3_4f3e;
        reset_sim       = 1'b1;
        i_trig_valid    = 1'b0;
        i_trig_op       = board_cfg_pkg::TRIG_NONE;
        i_trig_data     = '0;
        i_spike         = 1'b0;
        value_errors    = 0;
        timeout_errors  = 0;
        protocol_errors = 0;
        parse_errors    = 0;
        aborted         = 1'b0;
        tick_idx        = 0;
        // default lag 20 - 5
        lag             = int'(board_cfg_pkg::BLK_SIZE_DEFAULT)
                          - int'(spike_path_pkg::READ_WRITE_DIFF);
        ring_start      = 0;
        new_lag         = 0;
        new_start       = 0;
        switch_tick     = 0;
        restart_pending = 1'b0;
        switch_pending  = 1'b0;
        blk_model       = spike_path_pkg::ring_addr_t'(board_cfg_pkg::BLK_SIZE_DEFAULT);
        cycle_cnt       = 0;
        last_tick_cycle = 0;
        exp_period      = int'(board_cfg_pkg::HALF_CNT_DEFAULT) + 1;
        skip_period     = 1'b1;
        window_pending  = 1'b0;
        seen_valid      = 1'b0;
        last_raw        = '0;
        last_del        = '0;
        last_twice      = '0;

        repeat (3) @(posedge ep50trig);
        #10;
        reset_sim = 1'b0;

        fd = $fopen("spike_testdata.txt", "r");
        if (fd == 0)
        begin
            protocol_errors = protocol_errors + 1;
            $display("Could not open spike_testdata.txt");
        end
        else
        begin
            line_no = 0;
            while (!$feof(fd) && !aborted)
            begin
                line = "";
                rc = $fgets(line, fd);
                line_no = line_no + 1;
                // skip blanks and comment lines
                if (rc > 0 && line.len() > 1 && line[0] != "#")
                    run_record(line, line_no);
            end
            $fclose(fd);
        end
        if (window_pending && !aborted)
            next_cycle();

        total = value_errors + timeout_errors + protocol_errors + parse_errors;
        $display("errors: %0d value, %0d timeout, %0d protocol, %0d parse",
                 value_errors, timeout_errors, protocol_errors, parse_errors);
        if (total == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: tick_gen.sv
`timescale 1ns/1ps

module tick_gen
(
    input  logic                                    ep50trig,
    input  logic                                    reset_sim,
    input  logic [board_cfg_pkg::HALF_CNT_W-1:0]    i_half_cnt,
    output logic                                    o_tick,
    output logic                                    o_window_end
);

    logic [board_cfg_pkg::HALF_CNT_W-1:0]   div_cnt;
    spike_path_pkg::win_cnt_t               win_cnt;

    // tick at the top of the divider count
    // >= also catches a divider lowered below the running count
    assign o_tick = (div_cnt >= i_half_cnt);

    // last tick of each window
    assign o_window_end = o_tick && (win_cnt == spike_path_pkg::WIN_LAST);

    ////////////////////
    // counters
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            div_cnt <= '0;
            win_cnt <= '0;
        end
        else if (o_tick)
        begin
            // divider wraps, new half_cnt takes hold from here
            div_cnt <= '0;
            if (o_window_end)
                win_cnt <= '0;
            else
                win_cnt <= win_cnt + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule
